// File: hdl/exmon_consts.svh
// field widths and reservation entry count for the exclusive monitor
`ifndef EXMON_CONSTS_SVH
`define EXMON_CONSTS_SVH

// axi address and id.
`define EXMON_ADDR_W 32
`define EXMON_ID_W 8

// burst shape.
`define EXMON_LEN_W 8
`define EXMON_SIZE_W 3
`define EXMON_BURST_W 2

// match attributes and the uncompared qos.
`define EXMON_CACHE_W 4
`define EXMON_PROT_W 3
`define EXMON_QOS_W 4
`define EXMON_REGION_W 4

// any value of 2 or more.
`define EXMON_ENTRIES 4

`endif

// File: hdl/exmon_pkg.sv
// field typedefs, exclusive command struct, size and mask helper functions
`include "exmon_consts.svh"

package exmon_pkg;

	typedef logic [`EXMON_ADDR_W-1:0]   addr_t;
	typedef logic [`EXMON_ID_W-1:0]     id_t;
	typedef logic [`EXMON_LEN_W-1:0]    len_t;
	typedef logic [`EXMON_SIZE_W-1:0]   size_t;
	typedef logic [`EXMON_BURST_W-1:0]  burst_t;
	typedef logic [`EXMON_CACHE_W-1:0]  cache_t;
	typedef logic [`EXMON_PROT_W-1:0]   prot_t;
	typedef logic [`EXMON_QOS_W-1:0]    qos_t;
	typedef logic [`EXMON_REGION_W-1:0] region_t;
	typedef logic [12:0]                page_off_t; // 4 KB offset plus carry.
	typedef logic [`EXMON_ENTRIES-1:0]  ent_vec_t;

	typedef struct packed {
		logic    lock;
		id_t     id;
		addr_t   addr;
		size_t   size;
		burst_t  burst;
		len_t    len;
		cache_t  cache;
		prot_t   prot;
		qos_t    qos;
		region_t region;
	} ex_cmd_t;

	function automatic logic [7:0] size_bytes(size_t size);
		return 8'h01 << size; // bytes per beat.
	endfunction

	function automatic logic [7:0] size_mask(size_t size);
		return 8'hff << size; // clears the sub-beat bits.
	endfunction

endpackage

// File: hdl/exmon_ent.sv
// reservation entry: stored exclusive read, registered write window, overlap clear, valid bit
`timescale 1ns/10ps
`include "exmon_consts.svh"

module exmon_ent (
	input  logic               aclk,
	input  logic               reset_n,
	input  logic               set,
	input  logic               dec_err,
	input  logic               norm_clr,
	input  logic               exok_clr,
	input  exmon_pkg::ex_cmd_t rd_cmd,
	input  exmon_pkg::ex_cmd_t wr_cmd,
	output logic               match_exclusive,
	output exmon_pkg::id_t     ent_id,
	output logic               ent_valid
);
	localparam int PAGE_W = `EXMON_ADDR_W - 12;

	exmon_pkg::ex_cmd_t   rsv_cmd;
	exmon_pkg::page_off_t rd_start;
	exmon_pkg::page_off_t rd_end;
	logic [11:0]          wr_beats;
	exmon_pkg::page_off_t incr_beats;
	exmon_pkg::page_off_t incr_block;
	exmon_pkg::page_off_t incr_end;
	logic [11:0]          wrap_block;
	logic [11:0]          wrap_lo;
	exmon_pkg::page_off_t win_start_nx;
	exmon_pkg::page_off_t win_end_nx;
	exmon_pkg::page_off_t win_start;
	exmon_pkg::page_off_t win_end;
	logic [PAGE_W-1:0]    win_page;
	logic                 norm_clr_q;
	logic                 overlap;
	logic                 valid_clr;

	always_ff @(posedge aclk) begin
		if (set) begin
			rsv_cmd <= rd_cmd;
		end
	end

	assign ent_id = rsv_cmd.id;

	// bytes held by the reservation.
	assign rd_start = {1'b0, rsv_cmd.addr[11:0]};
	assign rd_end   = rd_start + {5'b0, exmon_pkg::size_bytes(rsv_cmd.size)} - 13'd1;

	assign wr_beats   = {{(12-`EXMON_LEN_W){1'b0}}, wr_cmd.len} + 12'd1;
	assign incr_beats = wr_cmd.burst[0] ? {1'b0, wr_beats} : 13'd1; // fixed is one beat.
	assign incr_block = incr_beats << wr_cmd.size;
	assign incr_end   = (({1'b0, wr_cmd.addr[11:0]} + incr_block)
		& {5'h1f, exmon_pkg::size_mask(wr_cmd.size)}) - 13'd1;

	// wrap covers the whole aligned block.
	assign wrap_block = wr_beats << wr_cmd.size;
	assign wrap_lo    = wrap_block - 12'd1;

	always_comb begin
		if (wr_cmd.burst[1]) begin
			win_start_nx = {1'b0, wr_cmd.addr[11:0] & ~wrap_lo};
			win_end_nx   = {1'b0, wr_cmd.addr[11:0] | wrap_lo};
		end else begin
			win_start_nx = {1'b0, wr_cmd.addr[11:0]};
			win_end_nx   = incr_end;
		end
	end

	always_ff @(posedge aclk) begin
		win_start <= win_start_nx;
		win_end   <= win_end_nx;
		win_page  <= wr_cmd.addr[`EXMON_ADDR_W-1:12];
	end

	always_ff @(posedge aclk or negedge reset_n) begin
		if (!reset_n) begin
			norm_clr_q <= 1'b0;
		end else begin
			norm_clr_q <= norm_clr;
		end
	end

	assign overlap = (win_start <= rd_end)
		&& (rd_start <= win_end)
		&& (win_page == rsv_cmd.addr[`EXMON_ADDR_W-1:12]);

	// qos is not part of the match.
	assign match_exclusive = ent_valid
		&& (rsv_cmd.addr   == wr_cmd.addr)
		&& (rsv_cmd.id     == wr_cmd.id)
		&& (rsv_cmd.size   == wr_cmd.size)
		&& (rsv_cmd.len    == wr_cmd.len)
		&& (rsv_cmd.cache  == wr_cmd.cache)
		&& (rsv_cmd.prot   == wr_cmd.prot)
		&& (rsv_cmd.burst  == wr_cmd.burst)
		&& (rsv_cmd.region == wr_cmd.region)
		&& (wr_cmd.len == '0);

	assign valid_clr = (overlap && (exok_clr || norm_clr_q)) || dec_err;

	always_ff @(posedge aclk or negedge reset_n) begin
		if (!reset_n) begin
			ent_valid <= 1'b0;
		end else if (set) begin
			ent_valid <= 1'b1; // set beats any clear.
		end else if (valid_clr) begin
			ent_valid <= 1'b0;
		end
	end

endmodule

// File: hdl/exmon_rsv_ctrl.sv
// reservation controller: entry choice on exclusive reads, release on read decode error
`timescale 1ns/10ps
`include "exmon_consts.svh"

module exmon_rsv_ctrl (
	input  logic                                        aclk,
	input  logic                                        reset_n,
	input  logic                                        ar_valid,
	input  exmon_pkg::ex_cmd_t                          ar_cmd,
	input  logic                                        rd_err,
	input  exmon_pkg::id_t                              rd_err_id,
	input  exmon_pkg::ent_vec_t                         ent_valid,
	input  exmon_pkg::id_t [`EXMON_ENTRIES-1:0]         ent_id,
	output exmon_pkg::ent_vec_t                         set,
	output exmon_pkg::ent_vec_t                         dec_err
);
	localparam int PTR_W = $clog2(`EXMON_ENTRIES);

	exmon_pkg::ent_vec_t same_id;
	exmon_pkg::ent_vec_t free_vec;
	exmon_pkg::ent_vec_t pick;
	logic [PTR_W-1:0]    victim_ptr;
	logic                ex_rd;
	logic                use_victim;

	assign ex_rd = ar_valid && ar_cmd.lock;

	always_comb begin
		for (int i = 0; i < `EXMON_ENTRIES; i++) begin
			same_id[i] = ent_valid[i] && (ent_id[i] == ar_cmd.id);
			dec_err[i] = rd_err && ent_valid[i] && (ent_id[i] == rd_err_id);
		end
	end

	assign free_vec = ~ent_valid;

	always_comb begin
		use_victim = 1'b0;
		if (|same_id) begin
			pick = same_id & (~same_id + exmon_pkg::ent_vec_t'(1)); // one id, one entry.
		end else if (|free_vec) begin
			pick = free_vec & (~free_vec + exmon_pkg::ent_vec_t'(1)); // lowest free.
		end else begin
			pick       = exmon_pkg::ent_vec_t'(1) << victim_ptr;
			use_victim = 1'b1;
		end
	end

	assign set = ex_rd ? pick : '0;

	// round robin over full table.
	always_ff @(posedge aclk or negedge reset_n) begin
		if (!reset_n) begin
			victim_ptr <= '0;
		end else if (ex_rd && use_victim) begin
			if (victim_ptr == PTR_W'(`EXMON_ENTRIES-1)) begin
				victim_ptr <= '0;
			end else begin
				victim_ptr <= victim_ptr + 1'b1;
			end
		end
	end

endmodule

// File: hdl/exmon_wr_check.sv
// write checker: match reduction, registered okay and fail verdicts, exclusive clear pulse
`timescale 1ns/10ps

module exmon_wr_check (
	input  logic                aclk,
	input  logic                reset_n,
	input  logic                aw_valid,
	input  logic                aw_lock,
	input  exmon_pkg::ent_vec_t match,
	output logic                exok_clr,
	output logic                ex_okay,
	output logic                ex_fail
);
	logic any_match;
	logic ex_wr;
	logic okay_nx;
	logic fail_nx;
	logic okay_q;
	logic fail_q;

	assign any_match = |match;
	assign ex_wr     = aw_valid && aw_lock; // unlocked writes give no verdict.

	assign okay_nx = ex_wr && any_match;
	assign fail_nx = ex_wr && !any_match;

	always_ff @(posedge aclk or negedge reset_n) begin
		if (!reset_n) begin
			okay_q <= 1'b0;
			fail_q <= 1'b0;
		end else begin
			okay_q <= okay_nx;
			fail_q <= fail_nx;
		end
	end

	// a good exclusive write also clears overlapping reservations.
	assign exok_clr = okay_q;
	assign ex_okay  = okay_q;
	assign ex_fail  = fail_q;

endmodule

// File: hdl/exmon.sv
// exclusive access monitor top: entry array, reservation controller, write checker
`timescale 1ns/10ps
`include "exmon_consts.svh"

module exmon (
	input  logic                aclk,
	input  logic                reset_n,
	input  logic                ar_valid,
	input  exmon_pkg::ex_cmd_t  ar_cmd,
	input  logic                rd_err,
	input  exmon_pkg::id_t      rd_err_id,
	input  logic                aw_valid,
	input  exmon_pkg::ex_cmd_t  aw_cmd,
	output logic                ex_okay,
	output logic                ex_fail,
	output exmon_pkg::ent_vec_t rsv_valid
);
	exmon_pkg::ent_vec_t                set;
	exmon_pkg::ent_vec_t                dec_err;
	exmon_pkg::ent_vec_t                match;
	exmon_pkg::ent_vec_t                ent_valid;
	exmon_pkg::id_t [`EXMON_ENTRIES-1:0] ent_id;
	logic                               norm_clr;
	logic                               exok_clr;

	assign norm_clr  = aw_valid && !aw_cmd.lock; // plain write.
	assign rsv_valid = ent_valid;

	exmon_rsv_ctrl u_rsv_ctrl (
		.aclk      (aclk),
		.reset_n   (reset_n),
		.ar_valid  (ar_valid),
		.ar_cmd    (ar_cmd),
		.rd_err    (rd_err),
		.rd_err_id (rd_err_id),
		.ent_valid (ent_valid),
		.ent_id    (ent_id),
		.set       (set),
		.dec_err   (dec_err)
	);

	for (genvar g = 0; g < `EXMON_ENTRIES; g++) begin : g_ent
		exmon_ent u_ent (
			.aclk            (aclk),
			.reset_n         (reset_n),
			.set             (set[g]),
			.dec_err         (dec_err[g]),
			.norm_clr        (norm_clr),
			.exok_clr        (exok_clr),
			.rd_cmd          (ar_cmd),
			.wr_cmd          (aw_cmd),
			.match_exclusive (match[g]),
			.ent_id          (ent_id[g]),
			.ent_valid       (ent_valid[g])
		);
	end

	exmon_wr_check u_wr_check (
		.aclk     (aclk),
		.reset_n  (reset_n),
		.aw_valid (aw_valid),
		.aw_lock  (aw_cmd.lock),
		.match    (match),
		.exok_clr (exok_clr),
		.ex_okay  (ex_okay),
		.ex_fail  (ex_fail)
	);

endmodule

// File: tests/tb_clk.sv
// testbench clock and reset generator
`timescale 1ns/10ps

module tb_clk #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 3
) (
	output logic aclk,
	output logic reset_n
);
	initial begin
		aclk = 1'b0;
		forever #(PERIOD / 2) aclk = ~aclk;
	end

	initial begin
		reset_n = 1'b0;
		repeat (RST_CYCLES) @(posedge aclk);
		@(negedge aclk);
		reset_n = 1'b1; // released between edges.
	end

endmodule

// File: tests/tb_exmon.sv
// testbench top: lfsr stimulus, reservation table model, output checks, timeout
`timescale 1ns/10ps
`include "exmon_consts.svh"

module tb_exmon;
	localparam int              N          = `EXMON_ENTRIES;
	localparam int              NUM_OPS    = 2000;
	localparam int              MAX_CYCLES = NUM_OPS + NUM_OPS / 4;
	localparam logic [31:0]     LFSR_SEED  = 32'h401368e7;
	localparam logic [31:0]     LFSR_TAPS  = 32'hb4bcd35c;
	localparam int              PG_W       = `EXMON_ADDR_W - 12;
	localparam logic [PG_W-1:0] PAGE_A     = 'h12345;
	localparam logic [PG_W-1:0] PAGE_B     = 'h80047;

	logic                aclk;
	logic                reset_n;
	logic                ar_valid;
	exmon_pkg::ex_cmd_t  ar_cmd;
	logic                rd_err;
	exmon_pkg::id_t      rd_err_id;
	logic                aw_valid;
	exmon_pkg::ex_cmd_t  aw_cmd;
	logic                ex_okay;
	logic                ex_fail;
	exmon_pkg::ent_vec_t rsv_valid;

	exmon_pkg::ex_cmd_t  m_cmd [N]; // model table.
	exmon_pkg::ent_vec_t m_valid;
	int                  m_victim;
	int                  p_lo; // write window waiting for its clear.
	int                  p_hi;
	logic [PG_W-1:0]     p_page;
	logic                p_clr;
	logic                exp_okay;
	logic                exp_fail;
	exmon_pkg::ent_vec_t exp_rsv;
	exmon_pkg::ex_cmd_t  recent [4];
	int                  recent_wr;
	logic [31:0]         lfsr_state;
	int                  val_errs;
	int                  misc_errs;
	int                  seen_okay;
	int                  seen_fail;
	int                  victim_uses;
	int                  cycles;

	tb_clk u_clk (
		.aclk    (aclk),
		.reset_n (reset_n)
	);

	exmon u_exmon (
		.aclk      (aclk),
		.reset_n   (reset_n),
		.ar_valid  (ar_valid),
		.ar_cmd    (ar_cmd),
		.rd_err    (rd_err),
		.rd_err_id (rd_err_id),
		.aw_valid  (aw_valid),
		.aw_cmd    (aw_cmd),
		.ex_okay   (ex_okay),
		.ex_fail   (ex_fail),
		.rsv_valid (rsv_valid)
	);

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	function automatic int unsigned rand_bits(int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | {31'b0, lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state); // one step per bit.
		end
		return v;
	endfunction

	function automatic logic [11:0] offset_at(int unsigned k);
		case (k)
			0: return 12'h000;
			1: return 12'h008;
			2: return 12'h010;
			3: return 12'h040;
			4: return 12'h080;
			5: return 12'h200;
			6: return 12'h400;
			default: return 12'h800;
		endcase
	endfunction

	function automatic exmon_pkg::ex_cmd_t random_cmd();
		exmon_pkg::ex_cmd_t c;
		logic [PG_W-1:0]    page;
		page     = (rand_bits(1) == 1) ? PAGE_A : PAGE_B;
		c.lock   = (rand_bits(1) == 1);
		c.id     = exmon_pkg::id_t'(8'h40 + rand_bits(3)); // more ids than entries.
		c.addr   = {page, offset_at(rand_bits(3))};
		c.size   = exmon_pkg::size_t'(rand_bits(2));
		c.burst  = exmon_pkg::burst_t'(rand_bits(2) % 3);
		c.len    = (rand_bits(1) == 1) ? '0 : exmon_pkg::len_t'((1 << rand_bits(2)) - 1);
		c.cache  = (rand_bits(1) == 1) ? 4'h3 : 4'hf;
		c.prot   = (rand_bits(1) == 1) ? 3'b000 : 3'b010;
		c.qos    = exmon_pkg::qos_t'(rand_bits(4));
		c.region = exmon_pkg::region_t'(rand_bits(1));
		return c;
	endfunction

	// locked writes mostly replay a recent exclusive read.
	function automatic exmon_pkg::ex_cmd_t make_write();
		exmon_pkg::ex_cmd_t c;
		c = random_cmd();
		if (c.lock && (rand_bits(2) != 0)) begin
			c      = recent[rand_bits(2)];
			c.lock = 1'b1;
			c.qos  = exmon_pkg::qos_t'(rand_bits(4)); // not compared.
			if (rand_bits(2) == 0) begin
				case (rand_bits(2))
					0: c.cache = c.cache ^ 4'h1;
					1: c.len = 8'h01;
					2: c.region = c.region ^ 4'h1;
					default: c.addr = c.addr + exmon_pkg::addr_t'(4);
				endcase
			end
		end
		return c;
	endfunction

	// byte window of a write inside its page.
	function automatic void write_window(input exmon_pkg::ex_cmd_t c, output int lo,
		output int hi);
		int beat;
		int beats;
		int base;
		int block;
		beat  = 1 << c.size;
		beats = int'(c.len) + 1;
		base  = int'(c.addr[11:0]);
		if (c.burst == 2'b10) begin
			block = beats * beat;
			lo    = base - (base % block);
			hi    = lo + block - 1;
		end else begin
			if (c.burst == 2'b00) begin
				beats = 1;
			end
			lo = base;
			hi = ((base + beats * beat) / beat) * beat - 1;
		end
	endfunction

	function automatic logic read_overlaps(exmon_pkg::ex_cmd_t r, int lo, int hi,
		logic [PG_W-1:0] page);
		int r_lo;
		int r_hi;
		r_lo = int'(r.addr[11:0]);
		r_hi = r_lo + (1 << r.size) - 1;
		return (lo <= r_hi) && (r_lo <= hi) && (r.addr[`EXMON_ADDR_W-1:12] == page);
	endfunction

	function automatic logic same_attrs(exmon_pkg::ex_cmd_t a, exmon_pkg::ex_cmd_t b);
		return (a.addr == b.addr) && (a.id == b.id) && (a.size == b.size)
			&& (a.len == b.len) && (a.cache == b.cache) && (a.prot == b.prot)
			&& (a.burst == b.burst) && (a.region == b.region);
	endfunction

	task automatic drive_op();
		ar_valid  = (rand_bits(1) == 1);
		ar_cmd    = random_cmd();
		rd_err    = (rand_bits(3) == 0);
		rd_err_id = recent[rand_bits(2)].id;
		aw_valid  = (rand_bits(1) == 1);
		aw_cmd    = make_write();
		if (ar_valid && ar_cmd.lock) begin
			recent[recent_wr] = ar_cmd;
			recent_wr = (recent_wr + 1) % 4;
		end
	endtask

	// one cycle of the table and the outputs it predicts for the next cycle.
	task automatic model_step();
		exmon_pkg::ent_vec_t clr;
		logic                any_match;
		int                  pick;
		any_match = 1'b0;
		pick      = -1;
		for (int i = 0; i < N; i++) begin
			clr[i] = (p_clr && read_overlaps(m_cmd[i], p_lo, p_hi, p_page))
				|| (rd_err && m_valid[i] && (m_cmd[i].id == rd_err_id));
			if (m_valid[i] && same_attrs(m_cmd[i], aw_cmd) && (aw_cmd.len == '0)) begin
				any_match = 1'b1;
			end
		end
		if (ar_valid && ar_cmd.lock) begin
			for (int i = N - 1; i >= 0; i--) begin
				if (m_valid[i] && (m_cmd[i].id == ar_cmd.id)) begin
					pick = i;
				end
			end
			if (pick < 0) begin
				for (int i = N - 1; i >= 0; i--) begin
					if (!m_valid[i]) begin
						pick = i; // lowest free entry.
					end
				end
			end
			if (pick < 0) begin
				pick     = m_victim;
				m_victim = (m_victim + 1) % N;
				victim_uses++;
			end
		end
		for (int i = 0; i < N; i++) begin
			if (i == pick) begin
				m_valid[i] = 1'b1; // set beats a clear.
				m_cmd[i]   = ar_cmd;
			end else if (clr[i]) begin
				m_valid[i] = 1'b0;
			end
		end
		exp_okay = aw_valid && aw_cmd.lock && any_match;
		exp_fail = aw_valid && aw_cmd.lock && !any_match;
		exp_rsv  = m_valid;
		write_window(aw_cmd, p_lo, p_hi);
		p_page = aw_cmd.addr[`EXMON_ADDR_W-1:12];
		p_clr  = exp_okay || (aw_valid && !aw_cmd.lock);
	endtask

	task automatic check_outputs();
		assert (ex_okay === exp_okay) else begin
			val_errs++;
			$display("ERR %0t ex_okay expected %0b actual %0b", $time, exp_okay, ex_okay);
		end
		assert (ex_fail === exp_fail) else begin
			val_errs++;
			$display("ERR %0t ex_fail expected %0b actual %0b", $time, exp_fail, ex_fail);
		end
		assert (rsv_valid === exp_rsv) else begin
			val_errs++;
			$display("ERR %0t rsv_valid expected %b actual %b", $time, exp_rsv, rsv_valid);
		end
		if (ex_okay) begin
			seen_okay++;
		end
		if (ex_fail) begin
			seen_fail++;
		end
	endtask

	initial begin : watchdog
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge aclk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		ar_valid    = 1'b0;
		ar_cmd      = '0;
		rd_err      = 1'b0;
		rd_err_id   = '0;
		aw_valid    = 1'b0;
		aw_cmd      = '0;
		lfsr_state  = LFSR_SEED;
		m_valid     = '0;
		m_victim    = 0;
		p_lo        = 0;
		p_hi        = 0;
		p_page      = '0;
		p_clr       = 1'b0;
		exp_okay    = 1'b0;
		exp_fail    = 1'b0;
		exp_rsv     = '0;
		recent_wr   = 0;
		val_errs    = 0;
		misc_errs   = 0;
		seen_okay   = 0;
		seen_fail   = 0;
		victim_uses = 0;
		for (int i = 0; i < N; i++) begin
			m_cmd[i] = '0;
		end
		for (int i = 0; i < 4; i++) begin
			recent[i] = '0;
		end
		@(posedge reset_n);
		for (int op = 0; op < NUM_OPS; op++) begin
			check_outputs(); // first pass sees the reset values.
			drive_op();
			model_step();
			@(negedge aclk);
		end
		check_outputs();
		ar_valid = 1'b0;
		aw_valid = 1'b0;
		rd_err   = 1'b0;
		assert ((seen_okay > 0) && (seen_fail > 0)) else begin
			misc_errs++;
			$display("the run never produced both an exclusive okay and an exclusive fail");
		end
		assert (victim_uses > 0) else begin
			misc_errs++;
			$display("the reservation table never filled, so no victim entry was chosen");
		end
		$display("errors: %0d wrong values, %0d other failures", val_errs, misc_errs);
		if ((val_errs == 0) && (misc_errs == 0)) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: exmon.f
+incdir+hdl
hdl/exmon_pkg.sv
hdl/exmon_ent.sv
hdl/exmon_rsv_ctrl.sv
hdl/exmon_wr_check.sv
hdl/exmon.sv
tests/tb_clk.sv
tests/tb_exmon.sv

// File: Makefile
# Verilator build and run for the exclusive monitor testbench.
VERILATOR ?= verilator
TOP       ?= tb_exmon
FILELIST  ?= exmon.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with $(VERILATOR), run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass message in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
